/* source/cpuPkg.sv */
// ================================================
// pipeline-level instruction types shared by the MEM stage blocks
// import inside a module body, use scoped names in port lists
// ================================================
package cpuPkg;

    // access width, shared by loads and stores
    typedef enum logic [1:0] {
        szByte = 2'd0,
        szHalf = 2'd1,
        szWord = 2'd2
    } accessSizeT;

    typedef struct packed {
        logic       readMem;
        logic       isSigned;    // sign-extend the loaded lane
        accessSizeT size;
    } loadTypeT;

    typedef struct packed {
        logic       dmWr;
        accessSizeT size;
    } storeTypeT;

    // write-back source
    typedef enum logic [1:0] {
        wbAluOut = 2'd0,
        wbOutB   = 2'd1,
        wbDmOut  = 2'd2
    } wbSelT;

    typedef struct packed {
        logic rfWr;
    } regsWrT;

    typedef struct packed {
        logic syscall;
        logic eret;
        logic adEL;    // load address error
        logic adES;    // store address error
        logic reserved;
    } exceptT;

    // execute -> MEM bundle
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;    // also the data address
        logic [31:0] outB;      // store operand
        logic [4:0]  dst;
        loadTypeT    loadType;
        storeTypeT   storeType;
        wbSelT       wbSel;
        regsWrT      regsWr;
        exceptT      exceptType;
    } exeMemT;

    // MEM -> WB bundle
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] dmOut;
        logic [4:0]  dst;
        wbSelT       wbSel;
        regsWrT      regsWr;        // after exception suppression
        exceptT      exceptType;
    } memWbT;

    // MIPS cause.ExcCode values
    typedef enum logic [4:0] {
        excInt  = 5'h00,
        excAdEL = 5'h04,
        excAdES = 5'h05,
        excSys  = 5'h08
    } excCodeT;

endpackage

/* source/memPkg.sv */
// ================================================
// memory-side widths and structs for the data RAM port
// ================================================
package memPkg;

    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int strbWidth = dataWidth / 8;    // one strobe per byte lane

    // single-cycle RAM request, we only meaningful with valid
    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
        logic [strbWidth-1:0] wstrb;
    } ramReqT;

    // what the load shaper needs from the registered instruction
    typedef struct packed {
        logic [1:0] offset;     // byte offset inside the word
        logic       signExt;
    } memCtlT;

endpackage

/* source/memRequest.sv */
// ================================================
// request side of the MEM stage that builds the RAM request from the
// execute bundle, places store data in its lanes and flags misalignment
// ================================================
module memRequest (
    input  cpuPkg::exeMemT exeBus,
    input  logic           memWr,     // stage may advance
    output memPkg::ramReqT ramReq,
    output cpuPkg::exeMemT exeChecked
);

    import cpuPkg::*;
    import memPkg::*;

    logic                 isLoad;
    logic                 isStore;
    logic                 misaligned;
    logic                 issue;
    logic [1:0]           offset;
    accessSizeT           size;
    logic [strbWidth-1:0] laneMask;

    always_comb begin
        isLoad  = exeBus.valid && exeBus.loadType.readMem;
        isStore = exeBus.valid && exeBus.storeType.dmWr;
        size    = isStore ? exeBus.storeType.size : exeBus.loadType.size;
        offset  = exeBus.aluOut[1:0];

        // half needs bit 0 clear, word needs both clear
        case (size)
            szHalf:  misaligned = offset[0];
            szWord:  misaligned = |offset;
            default: misaligned = 1'b0;
        endcase

        exeChecked = exeBus;
        exeChecked.exceptType.adEL = exeBus.exceptType.adEL || (isLoad && misaligned);
        exeChecked.exceptType.adES = exeBus.exceptType.adES || (isStore && misaligned);

        // a stalled cycle issues nothing, so a held store is written once
        issue = memWr && (isLoad || isStore) && !misaligned;

        case (size)
            szByte:  laneMask = 4'b0001 << offset;
            szHalf:  laneMask = 4'b0011 << offset;
            default: laneMask = 4'b1111;
        endcase

        ramReq.valid = issue;
        ramReq.we    = issue && isStore;
        ramReq.addr  = exeBus.aluOut;
        ramReq.wstrb = ramReq.we ? laneMask : '0;

        case (size)    // replicate so every candidate lane carries the data
            szByte:  ramReq.wdata = {4{exeBus.outB[7:0]}};
            szHalf:  ramReq.wdata = {2{exeBus.outB[15:0]}};
            default: ramReq.wdata = exeBus.outB;
        endcase

        // size selection assumes a slot is never both a load and a store
        assert (!(isLoad && isStore))
            else $error("memRequest: load and store in the same slot");
    end

endmodule

/* source/memStageReg.sv */
// ================================================
// MEM pipeline register that holds on stall and loads a bubble on flush
// ================================================
module memStageReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           memFlush,    // bubble at this edge
    input  logic           memWr,       // low holds the stage
    input  cpuPkg::exeMemT exeChecked,
    output cpuPkg::exeMemT memQ
);

    // flush wins over capture
    always_ff @(posedge clk) begin
        if (!rstN || memFlush) begin
            memQ <= '0;
        end else if (memWr) begin
            memQ <= exeChecked;
        end
    end

endmodule

/* source/dataRam.sv */
// ================================================
// byte-strobed synchronous data RAM with one-cycle read latency
// word address wraps at the parameterized depth
// ================================================
module dataRam #(
    parameter int memDepthWords = 256
) (
    input  logic                         clk,
    input  memPkg::ramReqT               ramReq,
    output logic [memPkg::dataWidth-1:0] rdata
);

    import memPkg::*;

    localparam int idxWidth = (memDepthWords > 1) ? $clog2(memDepthWords) : 1;

    logic [dataWidth-1:0] mem [memDepthWords];
    logic [addrWidth-3:0] wordAddr;
    logic [idxWidth-1:0]  wordIdx;

    assign wordAddr = ramReq.addr[addrWidth-1:2];    // drop byte offset
    assign wordIdx  = idxWidth'(wordAddr % memDepthWords);

    // contents start cleared
    initial begin
        for (int i = 0; i < memDepthWords; i++) begin
            mem[i] = '0;
        end
    end

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (ramReq.valid) begin
            rdata <= mem[wordIdx];
            for (int b = 0; b < strbWidth; b++) begin
                if (ramReq.we && ramReq.wstrb[b]) begin
                    mem[wordIdx][8*b +: 8] <= ramReq.wdata[8*b +: 8];
                end
            end
        end
    end

    // a write enable outside a valid request would be dropped here
    weNeedsValid: assert property (
        @(posedge clk) ramReq.we |-> ramReq.valid
    ) else $error("dataRam: write enable without a valid request");

    writeHasStrobe: assert property (
        @(posedge clk) (ramReq.valid && ramReq.we) |-> (ramReq.wstrb != '0)
    ) else $error("dataRam: write request with no byte strobe");

endmodule

/* source/memException.sv */
// ================================================
// exception / eret ranking for the instruction in MEM
// drives the pipeline flushes and the final register write enable
// ================================================
module memException (
    input  cpuPkg::exeMemT  memQ,
    input  logic [31:0]     cp0Status,
    input  logic [31:0]     cp0Cause,
    output cpuPkg::regsWrT  regsWrFinal,
    output cpuPkg::exceptT  exceptFinal,
    output cpuPkg::excCodeT excCode,
    output logic            idFlushExc,
    output logic            exeFlushExc,
    output logic            memFlushExc,
    output logic [1:0]      isExceptionOrEret    // 01 exception, 10 eret
);

    import cpuPkg::*;

    logic intPending;
    logic excTaken;
    logic eretTaken;

    always_comb begin
        // IE set, EXL clear, some unmasked line pending
        intPending = cp0Status[0] && !cp0Status[1] &&
                     |(cp0Cause[15:8] & cp0Status[15:8]);

        excTaken  = 1'b0;
        eretTaken = 1'b0;
        excCode   = excInt;

        if (memQ.valid) begin
            if (intPending) begin
                excTaken = 1'b1;
            end else if (memQ.exceptType.adEL) begin
                excTaken = 1'b1;
                excCode  = excAdEL;
            end else if (memQ.exceptType.adES) begin
                excTaken = 1'b1;
                excCode  = excAdES;
            end else if (memQ.exceptType.syscall) begin
                excTaken = 1'b1;
                excCode  = excSys;
            end else if (memQ.exceptType.eret) begin
                eretTaken = 1'b1;    // only when nothing above fired
            end
        end

        isExceptionOrEret = {eretTaken, excTaken};
        idFlushExc        = excTaken || eretTaken;
        exeFlushExc       = excTaken || eretTaken;
        memFlushExc       = excTaken || eretTaken;

        // the faulting instruction must not commit its result
        regsWrFinal.rfWr = memQ.valid && memQ.regsWr.rfWr && !excTaken;
        exceptFinal      = memQ.valid ? memQ.exceptType : '0;
    end

endmodule

/* source/loadAlign.sv */
// ================================================
// load shaping for the registered instruction
// picks the byte or half lane, extends it, and selects the forward value
// ================================================
module loadAlign (
    input  cpuPkg::exeMemT memQ,
    input  logic [31:0]    rdata,          // word read at the capture edge
    output logic [31:0]    dmOut,
    output logic [31:0]    forwardResult
);

    import cpuPkg::*;
    import memPkg::*;

    memCtlT      ctl;
    logic [7:0]  lane8;
    logic [15:0] lane16;
    logic        fill8;
    logic        fill16;

    always_comb begin
        ctl.offset  = memQ.aluOut[1:0];
        ctl.signExt = memQ.loadType.isSigned;

        lane8  = rdata[8*ctl.offset +: 8];
        lane16 = ctl.offset[1] ? rdata[31:16] : rdata[15:0];    // half is aligned

        fill8  = ctl.signExt && lane8[7];
        fill16 = ctl.signExt && lane16[15];

        case (memQ.loadType.size)
            szByte:  dmOut = {{24{fill8}}, lane8};
            szHalf:  dmOut = {{16{fill16}}, lane16};
            default: dmOut = rdata;
        endcase
    end

    // forwarding sees the store operand only for outB write-back
    always_comb begin
        if (memQ.wbSel == wbOutB) begin
            forwardResult = memQ.outB;
        end else begin
            forwardResult = memQ.aluOut;
        end
    end

endmodule

/* source/memStage.sv */
// ================================================
// memory-access stage top: request, pipeline register, data RAM,
// exception ranking and load shaping, one clock from exeBus to memBus
// ================================================
module memStage #(
    parameter int memDepthWords = 256
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  memFlush,
    input  logic                  memWr,
    input  logic [31:0]           cp0Status,
    input  logic [31:0]           cp0Cause,
    input  cpuPkg::exeMemT        exeBus,
    output cpuPkg::memWbT         memBus,
    output logic [31:0]           forwardResult,
    output cpuPkg::excCodeT       excCode,
    output logic                  idFlushExc,
    output logic                  exeFlushExc,
    output logic                  memFlushExc,
    output logic [1:0]            isExceptionOrEret
);

    import cpuPkg::*;
    import memPkg::*;

    ramReqT               ramReq;
    exeMemT               exeChecked;    // exeBus plus address errors
    exeMemT               memQ;
    logic [dataWidth-1:0] rdata;
    logic [31:0]          dmOut;
    regsWrT               regsWrFinal;
    exceptT               exceptFinal;

    memRequest uMemRequest (
        .exeBus     (exeBus),
        .memWr      (memWr),
        .ramReq     (ramReq),
        .exeChecked (exeChecked)
    );

    memStageReg uMemStageReg (
        .clk        (clk),
        .rstN       (rstN),
        .memFlush   (memFlush),
        .memWr      (memWr),
        .exeChecked (exeChecked),
        .memQ       (memQ)
    );

    dataRam #(.memDepthWords(memDepthWords)) uDataRam (
        .clk    (clk),
        .ramReq (ramReq),
        .rdata  (rdata)
    );

    memException uMemException (
        .memQ              (memQ),
        .cp0Status         (cp0Status),
        .cp0Cause          (cp0Cause),
        .regsWrFinal       (regsWrFinal),
        .exceptFinal       (exceptFinal),
        .excCode           (excCode),
        .idFlushExc        (idFlushExc),
        .exeFlushExc       (exeFlushExc),
        .memFlushExc       (memFlushExc),
        .isExceptionOrEret (isExceptionOrEret)
    );

    loadAlign uLoadAlign (
        .memQ          (memQ),
        .rdata         (rdata),
        .dmOut         (dmOut),
        .forwardResult (forwardResult)
    );

    assign memBus = '{
        valid:      memQ.valid,
        pc:         memQ.pc,
        aluOut:     memQ.aluOut,
        dmOut:      dmOut,
        dst:        memQ.dst,
        wbSel:      memQ.wbSel,
        regsWr:     regsWrFinal,
        exceptType: exceptFinal
    };

endmodule

/* tb/memStageChecker.sv */
// ==================================================
// watches the MEM stage outputs and compares them with the expected values
// one line per finished test, running counts go back to the testbench top
// ==================================================
module memStageChecker (
    input  logic              clk,
    input  logic              checkEn,     // expected values valid this cycle
    input  logic              testDone,
    input  logic [8*16-1:0]   testName,
    input  cpuPkg::memWbT     expBus,
    input  logic [31:0]       expFwd,
    input  cpuPkg::excCodeT   expCode,
    input  logic [2:0]        expFlush,
    input  logic [1:0]        expIsExc,
    input  cpuPkg::memWbT     memBus,
    input  logic [31:0]       forwardResult,
    input  cpuPkg::excCodeT   excCode,
    input  logic [2:0]        flushes,     // id, exe, mem
    input  logic [1:0]        isExceptionOrEret,
    output int                errCount,
    output int                checkCount
);

    import cpuPkg::*;

    int    errs = 0;
    int    checks = 0;
    int    testErrs = 0;
    int    testChecks = 0;
    memWbT expRest;
    memWbT actRest;

    assign errCount   = errs;
    assign checkCount = checks;

    task automatic compareField(input string field, input logic [127:0] expVal,
                                input logic [127:0] actVal);
        checks++;
        testChecks++;
        if (actVal !== expVal) begin
            errs++;
            testErrs++;
            $display("** Error %0s %0s: expected %0h actual %0h",
                     testName, field, expVal, actVal);
        end
    endtask

    // outputs settle after the edge, so compare in the middle of the cycle
    always @(negedge clk) begin
        if (checkEn) begin
            expRest       = expBus;
            actRest       = memBus;
            expRest.dmOut = '0;    // dmOut checked on its own
            actRest.dmOut = '0;
            compareField("memBus", 128'(expRest), 128'(actRest));
            if (expBus.valid) begin
                compareField("dmOut", 128'(expBus.dmOut), 128'(memBus.dmOut));
            end
            compareField("forwardResult", 128'(expFwd), 128'(forwardResult));
            compareField("flushes", 128'(expFlush), 128'(flushes));
            compareField("isExceptionOrEret", 128'(expIsExc), 128'(isExceptionOrEret));
            if (expIsExc[0]) begin
                compareField("excCode", 128'(expCode), 128'(excCode));
            end
        end
        if (testDone) begin
            $display("%0s finished: %0d checks, %0d mismatches", testName, testChecks, testErrs);
            testChecks = 0;
            testErrs   = 0;
        end
    end

endmodule

/* tb/memStageTb.sv */
// ==================================================
// MEM stage testbench: issues one instruction per cycle, keeps a shadow of
// the stage register, RAM and read port, and gives the overall result
// ==================================================
module memStageTb;

    import cpuPkg::*;

    localparam int depth     = 256;
    localparam int numWords  = 16;
    localparam int numCycles = 4 + 2 * numWords + 42 + 6 * 2;    // reset, tests, test ends
    localparam int timeLimit = numCycles * 10 + 200;

    typedef struct packed {
        memWbT       bus;
        logic [31:0] fwd;
        excCodeT     code;
        logic [2:0]  flush;
        logic [1:0]  isExc;
    } expectT;

    logic            clk = 1'b0;
    logic            rstN, memFlush, memWr;
    logic [31:0]     cp0Status, cp0Cause, forwardResult, shadowRd, data;
    exeMemT          exeBus, shadowQ, e;
    memWbT           memBus;
    excCodeT         excCode;
    logic            idFlushExc, exeFlushExc, memFlushExc;
    logic [1:0]      isExceptionOrEret;
    logic [2:0]      flushes;
    expectT          expected;
    logic            checkEn, testDone;
    logic [8*16-1:0] testName, shadowName;
    logic [31:0]     shadowMem [depth];
    logic [31:0]     addrs [numWords];
    int              seed = 92;
    int              errCount, checkCount;

    always #5 clk = ~clk;

    assign flushes = {idFlushExc, exeFlushExc, memFlushExc};

    memStage #(.memDepthWords(depth)) u_dut (
        .clk(clk), .rstN(rstN), .memFlush(memFlush), .memWr(memWr),
        .cp0Status(cp0Status), .cp0Cause(cp0Cause), .exeBus(exeBus),
        .memBus(memBus), .forwardResult(forwardResult), .excCode(excCode),
        .idFlushExc(idFlushExc), .exeFlushExc(exeFlushExc), .memFlushExc(memFlushExc),
        .isExceptionOrEret(isExceptionOrEret)
    );

    memStageChecker uChecker (
        .clk(clk), .checkEn(checkEn), .testDone(testDone), .testName(testName),
        .expBus(expected.bus), .expFwd(expected.fwd), .expCode(expected.code),
        .expFlush(expected.flush), .expIsExc(expected.isExc),
        .memBus(memBus), .forwardResult(forwardResult), .excCode(excCode),
        .flushes(flushes), .isExceptionOrEret(isExceptionOrEret),
        .errCount(errCount), .checkCount(checkCount)
    );

    // stage outputs for a registered instruction and the last read word
    function automatic expectT refOutputs(exeMemT q, logic [31:0] rd, logic [31:0] st,
                                          logic [31:0] ca);
        expectT     r;
        logic [7:0]  b;
        logic [15:0] h;
        logic        intr;
        logic        exc;
        logic        eret;
        r = '0;
        b = rd[8*int'(q.aluOut[1:0]) +: 8];
        h = q.aluOut[1] ? rd[31:16] : rd[15:0];
        case (q.loadType.size)
            szByte:  r.bus.dmOut = q.loadType.isSigned ? {{24{b[7]}}, b} : {24'd0, b};
            szHalf:  r.bus.dmOut = q.loadType.isSigned ? {{16{h[15]}}, h} : {16'd0, h};
            default: r.bus.dmOut = rd;
        endcase
        intr = st[0] && !st[1] && (|(st[15:8] & ca[15:8]));
        exc  = q.valid && (intr || q.exceptType.adEL || q.exceptType.adES ||
                           q.exceptType.syscall);
        eret = q.valid && !exc && q.exceptType.eret;
        if (intr) r.code = excInt;
        else if (q.exceptType.adEL) r.code = excAdEL;
        else if (q.exceptType.adES) r.code = excAdES;
        else r.code = excSys;
        r.isExc            = {eret, exc};
        r.flush            = {3{exc || eret}};
        r.bus.valid        = q.valid;
        r.bus.pc           = q.pc;
        r.bus.aluOut       = q.aluOut;
        r.bus.dst          = q.dst;
        r.bus.wbSel        = q.wbSel;
        r.bus.regsWr.rfWr  = q.valid && q.regsWr.rfWr && !exc;
        r.bus.exceptType   = q.valid ? q.exceptType : '0;
        r.fwd              = (q.wbSel == wbOutB) ? q.outB : q.aluOut;
        return r;
    endfunction

    function automatic exeMemT makeInstr(logic ld, logic st, accessSizeT sz, logic sgn,
                                         logic [31:0] addr, logic [31:0] wdata);
        exeMemT x;
        x           = '0;
        x.valid     = 1'b1;
        x.pc        = 32'h0040_0000 + addr;
        x.aluOut    = addr;
        x.outB      = wdata;
        x.dst       = addr[6:2];
        x.loadType  = '{ld, sgn, sz};
        x.storeType = '{st, sz};
        x.wbSel     = ld ? wbDmOut : wbAluOut;
        x.regsWr.rfWr = !st;
        return x;
    endfunction

    // drive one instruction, arm the check of the previous one, advance the shadow
    task automatic issue(input exeMemT ins, input logic wr, input logic flush,
                         input logic [8*16-1:0] name);
        exeMemT     chk;
        accessSizeT sz;
        logic       mis;
        int         idx;
        int         off;
        exeBus   = ins;
        memWr    = wr;
        memFlush = flush;
        expected = refOutputs(shadowQ, shadowRd, cp0Status, cp0Cause);
        testName = shadowName;
        checkEn  = 1'b1;
        sz  = ins.storeType.dmWr ? ins.storeType.size : ins.loadType.size;
        mis = (sz == szHalf && ins.aluOut[0]) || (sz == szWord && ins.aluOut[1:0] != 2'b00);
        chk = ins;
        chk.exceptType.adEL = ins.exceptType.adEL || (ins.valid && ins.loadType.readMem && mis);
        chk.exceptType.adES = ins.exceptType.adES || (ins.valid && ins.storeType.dmWr && mis);
        idx = int'(ins.aluOut[31:2]) % depth;
        off = int'(ins.aluOut[1:0]);
        if (wr && ins.valid && (ins.loadType.readMem || ins.storeType.dmWr) && !mis) begin
            shadowRd = shadowMem[idx];    // old word even on a write
            if (ins.storeType.dmWr) begin
                case (sz)
                    szByte:  shadowMem[idx][8*off +: 8]  = ins.outB[7:0];
                    szHalf:  shadowMem[idx][8*off +: 16] = ins.outB[15:0];
                    default: shadowMem[idx] = ins.outB;
                endcase
            end
        end
        if (flush || wr) shadowName = name;
        if (flush) shadowQ = '0;
        else if (wr) shadowQ = chk;
        @(posedge clk);
        #1;
    endtask

    // idle slot checks the last instruction, then the test line is printed
    task automatic endTest(input logic [8*16-1:0] name);
        issue('0, 1'b1, 1'b0, name);
        checkEn  = 1'b0;
        testName = name;
        testDone = 1'b1;
        @(posedge clk);
        #1;
        testDone = 1'b0;
    endtask

    initial begin
        rstN = 1'b0;
        memFlush = 1'b0;
        memWr = 1'b0;
        cp0Status = '0;
        cp0Cause = '0;
        exeBus = '0;
        checkEn = 1'b0;
        testDone = 1'b0;
        testName = '0;
        shadowName = '0;
        shadowQ = '0;
        shadowRd = '0;
        expected = '0;
        for (int i = 0; i < depth; i++) shadowMem[i] = '0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;

        for (int i = 0; i < numWords; i++) begin
            addrs[i] = $random(seed) & 32'h0000_0FFC;    // wraps past the depth
            issue(makeInstr(1'b0, 1'b1, szWord, 1'b0, addrs[i], $random(seed)),
                  1'b1, 1'b0, "wordStoreLoad");
        end
        for (int i = 0; i < numWords; i++) begin
            issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, addrs[i], '0), 1'b1, 1'b0, "wordStoreLoad");
        end
        endTest("wordStoreLoad");

        issue(makeInstr(1'b0, 1'b1, szWord, 1'b0, 32'h180, 32'hA5A5_A5A5), 1'b1, 1'b0, "byteHalf");
        for (int off = 0; off < 4; off++) begin
            data    = $random(seed);
            data[7] = off[0];    // both signs
            issue(makeInstr(1'b0, 1'b1, szByte, 1'b0, 32'h180 + off, data), 1'b1, 1'b0, "byteHalf");
            issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h180, '0), 1'b1, 1'b0, "byteHalf");
        end
        for (int off = 0; off < 4; off++) begin
            issue(makeInstr(1'b1, 1'b0, szByte, 1'b1, 32'h180 + off, '0), 1'b1, 1'b0, "byteHalf");
            issue(makeInstr(1'b1, 1'b0, szByte, 1'b0, 32'h180 + off, '0), 1'b1, 1'b0, "byteHalf");
        end
        for (int k = 0; k < 2; k++) begin
            data     = $random(seed);
            data[15] = k[0];
            issue(makeInstr(1'b0, 1'b1, szHalf, 1'b0, 32'h184 + 2 * k, data), 1'b1, 1'b0, "byteHalf");
        end
        for (int k = 0; k < 2; k++) begin
            issue(makeInstr(1'b1, 1'b0, szHalf, 1'b1, 32'h184 + 2 * k, '0), 1'b1, 1'b0, "byteHalf");
            issue(makeInstr(1'b1, 1'b0, szHalf, 1'b0, 32'h184 + 2 * k, '0), 1'b1, 1'b0, "byteHalf");
        end
        endTest("byteHalf");

        issue(makeInstr(1'b0, 1'b1, szWord, 1'b0, 32'h200, 32'h5A5A_C3C3), 1'b1, 1'b0, "addrError");
        issue(makeInstr(1'b1, 1'b0, szWord, 1'b1, 32'h201, '0), 1'b1, 1'b0, "addrError");
        issue(makeInstr(1'b0, 1'b1, szHalf, 1'b0, 32'h203, '1), 1'b1, 1'b0, "addrError");
        issue(makeInstr(1'b0, 1'b1, szWord, 1'b0, 32'h202, '0), 1'b1, 1'b0, "addrError");
        issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h200, '0), 1'b1, 1'b0, "addrError");
        endTest("addrError");

        cp0Status = 32'h0000_0401;    // IE with IM2, EXL clear
        cp0Cause  = 32'h0000_0400;
        issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h206, '0), 1'b1, 1'b0, "interruptOrder");
        e = makeInstr(1'b0, 1'b0, szWord, 1'b0, 32'h40, '0);
        e.exceptType.syscall = 1'b1;
        issue(e, 1'b1, 1'b0, "interruptOrder");
        cp0Status = '0;
        cp0Cause  = '0;
        e.exceptType = '0;
        e.exceptType.eret = 1'b1;
        issue(e, 1'b1, 1'b0, "interruptOrder");
        issue('0, 1'b1, 1'b0, "interruptOrder");
        cp0Status = 32'h0000_0401;    // pending line seen by a bubble
        cp0Cause  = 32'h0000_0400;
        issue('0, 1'b1, 1'b0, "interruptOrder");
        cp0Status = '0;
        cp0Cause  = '0;
        endTest("interruptOrder");

        issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h180, '0), 1'b1, 1'b1, "flushStall");
        issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h180, '0), 1'b1, 1'b0, "flushStall");
        e = makeInstr(1'b0, 1'b1, szWord, 1'b0, 32'h300, 32'hDEAD_BEEF);
        issue(e, 1'b0, 1'b0, "flushStall");
        issue(e, 1'b0, 1'b0, "flushStall");
        issue(makeInstr(1'b1, 1'b0, szWord, 1'b0, 32'h300, '0), 1'b1, 1'b0, "flushStall");
        endTest("flushStall");

        for (int k = 0; k < 4; k++) begin
            e = makeInstr(1'b0, 1'b0, szWord, 1'b0, $random(seed), $random(seed));
            e.wbSel = k[0] ? wbOutB : (k[1] ? wbDmOut : wbAluOut);
            issue(e, 1'b1, 1'b0, "forwarding");
        end
        endTest("forwarding");

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0 && checkCount > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(timeLimit);
        $display("timeout: run still going after %0d time units", timeLimit);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* sources.f */
source/cpuPkg.sv
source/memPkg.sv
source/memRequest.sv
source/memStageReg.sv
source/dataRam.sv
source/memException.sv
source/loadAlign.sv
source/memStage.sv
tb/memStageChecker.sv
tb/memStageTb.sv

/* run.sh */
#!/bin/sh
# build and run the MEM stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memStageTb -f sources.f -o memStageSim

out=$(./obj_dir/memStageSim)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi
